// File: verilog/ecc_defs.svh
/* widths and depth of the ECC scratchpad
   shared by the packages and every RTL module */
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// data word width, the code covers the whole word
`define ECC_DW 32

// six hamming check bits plus the overall parity bit
`define ECC_NB 7

// word address width and bank depth
`define ECC_AW 8
`define ECC_DEPTH 256

// stored codeword width
`define ECC_CW (`ECC_DW + `ECC_NB)

`endif

// File: verilog/hci_bus_pkg.sv
/* core-bus types: opcode enum, plain request and response,
   and the ECC-extended request and response toward the bank */
`include "ecc_defs.svh"

package hci_bus_pkg;

  // follows the hci wen sense, high means read
  typedef enum logic {
    OPC_WRITE = 1'b0,
    OPC_READ  = 1'b1
  } hci_opc_e;

  typedef struct packed {
    logic               req;
    hci_opc_e           opc;
    logic [`ECC_AW-1:0] add;
    logic [`ECC_DW-1:0] data;
  } hci_req_t;

  typedef struct packed {
    logic               r_valid;
    logic [`ECC_DW-1:0] r_data;
  } hci_rsp_t;

  // user carries the check bits next to the data
  typedef struct packed {
    logic               req;
    hci_opc_e           opc;
    logic [`ECC_AW-1:0] add;
    logic [`ECC_DW-1:0] data;
    logic [`ECC_NB-1:0] user;
  } hci_ecc_req_t;

  typedef struct packed {
    logic               r_valid;
    logic [`ECC_DW-1:0] r_data;
    logic [`ECC_NB-1:0] r_user;
  } hci_ecc_rsp_t;

endpackage

// File: verilog/ecc_pkg.sv
/* ECC types: stored codeword, error kind, APB phase, register map
   and the data-bit to hamming-position helper */
`include "ecc_defs.svh"

package ecc_pkg;

  // check bits sit above the data, as in the user field
  typedef struct packed {
    logic [`ECC_NB-1:0] check;
    logic [`ECC_DW-1:0] data;
  } ecc_word_t;

  // bit 0 flags a corrected error, bit 1 an uncorrectable one
  typedef enum logic [1:0] {
    ERR_NONE   = 2'b00,
    ERR_SINGLE = 2'b01,
    ERR_DOUBLE = 2'b10
  } ecc_err_e;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  // byte addresses of the register words
  typedef enum logic [7:0] {
    REG_CNT_SINGLE = 8'h00,
    REG_CNT_DOUBLE = 8'h04,
    REG_LAST_SYND  = 8'h08,
    REG_INJ_DATA   = 8'h0C,
    REG_INJ_CHECK  = 8'h10
  } ecc_reg_e;

  // hamming position of data bit idx, power-of-two slots belong to check bits
  function automatic logic [`ECC_NB-2:0] ecc_data_pos(input int unsigned idx);
    int unsigned cnt;
    logic [`ECC_NB-2:0] pos;
    cnt = 0;
    pos = '0;
    for (int unsigned p = 3; p < (1 << (`ECC_NB - 1)); p++) begin
      if (((p & (p - 1)) != 0) && (cnt <= idx)) begin
        pos = p[`ECC_NB-2:0];
        cnt++;
      end
    end
    return pos;
  endfunction

endpackage

// File: verilog/secded_39_32_enc.sv
/* SECDED (39,32) encoder, extended hamming layout
   six position parities plus overall parity */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module secded_39_32_enc (
  input  logic [`ECC_DW-1:0] data_i,
  output ecc_pkg::ecc_word_t code_o
);
  import ecc_pkg::*;

  logic [`ECC_NB-2:0] ham;

  // check bit k covers data bits whose position has bit k set
  always_comb begin
    logic [`ECC_NB-2:0] pos;
    ham = '0;
    for (int i = 0; i < `ECC_DW; i++) begin
      pos = ecc_data_pos(i);
      for (int k = 0; k < `ECC_NB - 1; k++) begin
        ham[k] = ham[k] ^ (data_i[i] & pos[k]);
      end
    end
  end

  assign code_o.data = data_i;
  assign code_o.check[`ECC_NB-2:0] = ham;
  // overall parity makes the whole codeword even
  assign code_o.check[`ECC_NB-1] = ^{ham, data_i};

endmodule

// File: verilog/secded_39_32_dec.sv
/* SECDED (39,32) decoder
   syndrome, single-bit correction and error classification */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module secded_39_32_dec (
  input  ecc_pkg::ecc_word_t  code_i,
  output logic [`ECC_DW-1:0]  data_o,
  output logic [`ECC_NB-1:0]  syndrome_o,
  output ecc_pkg::ecc_err_e   err_o
);
  import ecc_pkg::*;

  logic [`ECC_CW-1:0] code_flat;
  logic [`ECC_NB-1:0] syn;

  assign code_flat = {code_i.check, code_i.data};

  // recompute position parities and fold in the stored check bits
  always_comb begin
    logic [`ECC_NB-2:0] pos;
    syn = '0;
    for (int i = 0; i < `ECC_DW; i++) begin
      pos = ecc_data_pos(i);
      for (int k = 0; k < `ECC_NB - 1; k++) begin
        syn[k] = syn[k] ^ (code_i.data[i] & pos[k]);
      end
    end
    syn[`ECC_NB-2:0] = syn[`ECC_NB-2:0] ^ code_i.check[`ECC_NB-2:0];
    // top bit is the overall parity and goes high on an odd number of flips
    syn[`ECC_NB-1] = ^code_flat;
  end

  // flip the named data bit only when overall parity fails
  // a check-bit hit names a power of two and leaves data alone
  always_comb begin
    logic [`ECC_NB-2:0] pos;
    data_o = code_i.data;
    for (int i = 0; i < `ECC_DW; i++) begin
      pos = ecc_data_pos(i);
      if (syn[`ECC_NB-1] && (syn[`ECC_NB-2:0] == pos)) begin
        data_o[i] = ~code_i.data[i];
      end
    end
  end

  // even overall parity with a nonzero syndrome means two flips
  always_comb begin
    if (syn == '0) begin
      err_o = ERR_NONE;
    end else if (syn[`ECC_NB-1]) begin
      err_o = ERR_SINGLE;
    end else begin
      err_o = ERR_DOUBLE;
    end
  end

  assign syndrome_o = syn;

  // a clean syndrome reports no error and leaves the data untouched
  syn_zero_clean: assert final ((syndrome_o != '0) ||
    ((err_o == ERR_NONE) && (data_o == code_i.data)));

endmodule

// File: verilog/hci_ecc_adapter.sv
/* core-bus ECC adapter
   encodes write data into user, decodes and corrects read data */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module hci_ecc_adapter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  hci_bus_pkg::hci_req_t     bus_req_i,
  output logic                      bus_gnt_o,
  output hci_bus_pkg::hci_rsp_t     bus_rsp_o,
  output hci_bus_pkg::hci_ecc_req_t mem_req_o,
  input  hci_bus_pkg::hci_ecc_rsp_t mem_rsp_i,
  output logic                      err_valid_o,
  output ecc_pkg::ecc_err_e         err_kind_o,
  output logic [`ECC_NB-1:0]        syndrome_o
);
  import hci_bus_pkg::*;
  import ecc_pkg::*;

  ecc_word_t          wr_code;
  ecc_word_t          rd_code;
  logic [`ECC_DW-1:0] rd_data;
  logic [`ECC_NB-1:0] rd_syn;
  ecc_err_e           rd_err;

  // no back-pressure toward the requester
  assign bus_gnt_o = 1'b1;

  secded_39_32_enc u_enc (
    .data_i ( bus_req_i.data ),
    .code_o ( wr_code        )
  );

  // request passes on with check bits in the user field
  assign mem_req_o.req  = bus_req_i.req;
  assign mem_req_o.opc  = bus_req_i.opc;
  assign mem_req_o.add  = bus_req_i.add;
  assign mem_req_o.data = wr_code.data;
  assign mem_req_o.user = wr_code.check;

  // rebuild the stored codeword from the raw response
  assign rd_code.check = mem_rsp_i.r_user;
  assign rd_code.data  = mem_rsp_i.r_data;

  secded_39_32_dec u_dec (
    .code_i     ( rd_code ),
    .data_o     ( rd_data ),
    .syndrome_o ( rd_syn  ),
    .err_o      ( rd_err  )
  );

  assign bus_rsp_o.r_valid = mem_rsp_i.r_valid;
  assign bus_rsp_o.r_data  = rd_data;

  // error report only means something alongside a response
  assign err_valid_o = mem_rsp_i.r_valid;
  assign err_kind_o  = mem_rsp_i.r_valid ? rd_err : ERR_NONE;
  assign syndrome_o  = mem_rsp_i.r_valid ? rd_syn : '0;

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_i.r_valid |-> $past(bus_req_i.req && bus_gnt_o && (bus_req_i.opc == OPC_READ)));

endmodule

// File: verilog/ecc_sram_bank.sv
/* single-port codeword bank
   fault mask applied on writes, registered one-cycle read */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module ecc_sram_bank (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  hci_bus_pkg::hci_ecc_req_t req_i,
  input  ecc_pkg::ecc_word_t        inj_mask_i,
  output hci_bus_pkg::hci_ecc_rsp_t rsp_o
);
  import hci_bus_pkg::*;
  import ecc_pkg::*;

  ecc_word_t mem_q [`ECC_DEPTH];
  ecc_word_t wr_word;
  ecc_word_t rd_word_q;
  logic      wr_en;
  logic      rd_en;
  logic      r_valid_q;

  assign wr_en = req_i.req && (req_i.opc == OPC_WRITE);
  assign rd_en = req_i.req && (req_i.opc == OPC_READ);

  // mask flips the stored bits so a zero mask stores the clean codeword
  assign wr_word.check = req_i.user ^ inj_mask_i.check;
  assign wr_word.data  = req_i.data ^ inj_mask_i.data;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[req_i.add] <= wr_word;
    end
  end

  // read data register gives the one-cycle latency
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_word_q <= mem_q[req_i.add];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;
    end
  end

  assign rsp_o.r_valid = r_valid_q;
  assign rsp_o.r_data  = rd_word_q.data;
  assign rsp_o.r_user  = rd_word_q.check;

  addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |-> (!$isunknown(req_i.add) && (req_i.add < `ECC_DEPTH)));

endmodule

// File: verilog/ecc_apb_regs.sv
/* APB register block
   saturating error counters, last syndrome, fault-injection mask */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module ecc_apb_regs (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [7:0]         paddr_i,
  input  logic [`ECC_DW-1:0] pwdata_i,
  output logic [`ECC_DW-1:0] prdata_o,
  input  logic               err_valid_i,
  input  ecc_pkg::ecc_err_e  err_kind_i,
  input  logic [`ECC_NB-1:0] syndrome_i,
  output ecc_pkg::ecc_word_t inj_mask_o
);
  import ecc_pkg::*;

  apb_state_e         state_q;
  apb_state_e         state_d;
  logic               setup_rd;
  logic               access_wr;
  logic [`ECC_DW-1:0] rd_mux;
  logic [`ECC_DW-1:0] prdata_q;
  logic [`ECC_DW-1:0] cnt_single_q;
  logic [`ECC_DW-1:0] cnt_double_q;
  logic [`ECC_NB-1:0] last_synd_q;
  logic [`ECC_DW-1:0] inj_data_q;
  logic [`ECC_NB-1:0] inj_check_q;

  // phase of the current cycle, registered to qualify the access
  always_comb begin
    if (!psel_i) begin
      state_d = IDLE;
    end else if (!penable_i) begin
      state_d = SETUP;
    end else begin
      state_d = ACCESS;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read sampled in setup so prdata holds during access
  assign setup_rd  = (state_d == SETUP) && !pwrite_i;
  // write lands in the access cycle that follows a setup
  assign access_wr = (state_d == ACCESS) && (state_q == SETUP) && pwrite_i;

  always_comb begin
    case (paddr_i)
      REG_CNT_SINGLE: rd_mux = cnt_single_q;
      REG_CNT_DOUBLE: rd_mux = cnt_double_q;
      REG_LAST_SYND:  rd_mux = {{(`ECC_DW-`ECC_NB){1'b0}}, last_synd_q};
      REG_INJ_DATA:   rd_mux = inj_data_q;
      REG_INJ_CHECK:  rd_mux = {{(`ECC_DW-`ECC_NB){1'b0}}, inj_check_q};
      // unmapped reads back zero
      default:        rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prdata_q <= '0;
    end else begin
      prdata_q <= setup_rd ? rd_mux : '0;
    end
  end

  assign prdata_o = prdata_q;

  // counters stick at all ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_single_q <= '0;
      cnt_double_q <= '0;
      last_synd_q  <= '0;
    end else if (err_valid_i) begin
      if ((err_kind_i == ERR_SINGLE) && (cnt_single_q != '1)) begin
        cnt_single_q <= cnt_single_q + 1'b1;
      end
      if ((err_kind_i == ERR_DOUBLE) && (cnt_double_q != '1)) begin
        cnt_double_q <= cnt_double_q + 1'b1;
      end
      // clean reads keep the previous syndrome
      if (syndrome_i != '0) begin
        last_synd_q <= syndrome_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inj_data_q  <= '0;
      inj_check_q <= '0;
    end else if (access_wr) begin
      if (paddr_i == REG_INJ_DATA) begin
        inj_data_q <= pwdata_i;
      end
      if (paddr_i == REG_INJ_CHECK) begin
        inj_check_q <= pwdata_i[`ECC_NB-1:0];
      end
    end
  end

  assign inj_mask_o.data  = inj_data_q;
  assign inj_mask_o.check = inj_check_q;

  penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_i |-> psel_i);

endmodule

// File: verilog/ecc_mem_top.sv
/* ECC scratchpad top
   adapter, codeword bank and APB register block */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module ecc_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  hci_bus_pkg::hci_req_t bus_req_i,
  output logic                  bus_gnt_o,
  output hci_bus_pkg::hci_rsp_t bus_rsp_o,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  logic [7:0]            paddr_i,
  input  logic [`ECC_DW-1:0]    pwdata_i,
  output logic [`ECC_DW-1:0]    prdata_o
);
  import hci_bus_pkg::*;
  import ecc_pkg::*;

  // adapter to bank
  hci_ecc_req_t       mem_req;
  hci_ecc_rsp_t       mem_rsp;
  // adapter to registers
  logic               err_valid;
  ecc_err_e           err_kind;
  logic [`ECC_NB-1:0] syndrome;
  // registers to bank
  ecc_word_t          inj_mask;

  hci_ecc_adapter u_adapter (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .bus_req_i   ( bus_req_i ),
    .bus_gnt_o   ( bus_gnt_o ),
    .bus_rsp_o   ( bus_rsp_o ),
    .mem_req_o   ( mem_req   ),
    .mem_rsp_i   ( mem_rsp   ),
    .err_valid_o ( err_valid ),
    .err_kind_o  ( err_kind  ),
    .syndrome_o  ( syndrome  )
  );

  ecc_sram_bank u_bank (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .req_i      ( mem_req  ),
    .inj_mask_i ( inj_mask ),
    .rsp_o      ( mem_rsp  )
  );

  ecc_apb_regs u_regs (
    .clk_i       ( clk_i     ),
    .rst_n_i     ( rst_n_i   ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .prdata_o    ( prdata_o  ),
    .err_valid_i ( err_valid ),
    .err_kind_i  ( err_kind  ),
    .syndrome_i  ( syndrome  ),
    .inj_mask_o  ( inj_mask  )
  );

endmodule

// File: testbench/tb_ecc_mem.sv
/* testbench for the ECC scratchpad: clock, reset, random core-bus and APB
   stimulus, word-level reference model, checks and cycle watchdog */
`timescale 1ns/100ps
`include "ecc_defs.svh"

module tb_ecc_mem;
  import hci_bus_pkg::*;
  import ecc_pkg::*;

  localparam int N_CLEAN = 200;
  localparam int N_FAULT = 8;
  // cycle budget of each phase, rounded up from its task sequence
  localparam int RST_CYC   = 6;
  localparam int CLEAN_CYC = N_CLEAN + 16;
  localparam int FAULT_CYC = N_FAULT * 12 + 8;
  localparam int FIX_CYC   = N_FAULT * 8 + 8;
  localparam int APB_CYC   = 20;
  localparam int LIMIT = 4 * (RST_CYC + CLEAN_CYC + 2 * FAULT_CYC + FIX_CYC + APB_CYC);

  logic               clk;
  logic               rst_n;
  hci_req_t           bus_req;
  logic               bus_gnt;
  hci_rsp_t           bus_rsp;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [7:0]         paddr;
  logic [`ECC_DW-1:0] pwdata;
  logic [`ECC_DW-1:0] prdata;

  integer seed = 32'h3177_0cac;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;

  // reference model, data as written plus the mask data part and flip count
  logic [`ECC_DW-1:0] model_data [`ECC_DEPTH];
  logic [`ECC_DW-1:0] model_mask [`ECC_DEPTH];
  int                 model_flips [`ECC_DEPTH];
  bit                 written [`ECC_DEPTH];
  int                 exp_single = 0;
  int                 exp_double = 0;
  logic [7:0]         fault_addrs [$];

  ecc_mem_top dut (
    .clk_i     ( clk     ),
    .rst_n_i   ( rst_n   ),
    .bus_req_i ( bus_req ),
    .bus_gnt_o ( bus_gnt ),
    .bus_rsp_o ( bus_rsp ),
    .psel_i    ( psel    ),
    .penable_i ( penable ),
    .pwrite_i  ( pwrite  ),
    .paddr_i   ( paddr   ),
    .pwdata_i  ( pwdata  ),
    .prdata_o  ( prdata  )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout, run exceeded %0d cycles", LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  task automatic require(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // setup cycle then access cycle, pready is always high
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // prdata is registered at the end of setup, stable through access
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    rdata   = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_mask(input logic [38:0] mask);
    apb_write(REG_INJ_DATA, mask[31:0]);
    apb_write(REG_INJ_CHECK, {25'b0, mask[38:32]});
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata);
    bus_req.req  = 1'b1;
    bus_req.opc  = OPC_WRITE;
    bus_req.add  = addr;
    bus_req.data = wdata;
    @(negedge clk);
    require(bus_gnt, "write request was not granted");
    require(!bus_rsp.r_valid, "write produced a read response");
    bus_req.req = 1'b0;
  endtask

  // r_valid and data must be there one cycle after the grant
  task automatic bus_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
    bus_req.req  = 1'b1;
    bus_req.opc  = OPC_READ;
    bus_req.add  = addr;
    bus_req.data = '0;
    @(negedge clk);
    require(bus_gnt, "read request was not granted");
    require(bus_rsp.r_valid, "r_valid missing one cycle after a granted read");
    compare_value(name, exp, bus_rsp.r_data);
    bus_req.req = 1'b0;
  endtask

  task automatic store_word(input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [38:0] mask, input int flips);
    bus_write(addr, wdata);
    model_data[addr]  = wdata;
    model_mask[addr]  = mask[31:0];
    model_flips[addr] = flips;
    written[addr]     = 1'b1;
  endtask

  // one flip is corrected, two are flagged and the data passes uncorrected
  task automatic read_tracked(input logic [7:0] addr, input string name);
    logic [31:0] exp;
    exp = model_data[addr];
    if (model_flips[addr] == 2) begin
      exp = model_data[addr] ^ model_mask[addr];
    end
    bus_read(addr, exp, name);
    if (model_flips[addr] == 1) begin
      exp_single++;
    end else if (model_flips[addr] == 2) begin
      exp_double++;
    end
  endtask

  initial begin
    logic [7:0]  a;
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] rd;
    logic [38:0] mask;
    int          b1;
    int          b2;
    rst_n   = 1'b0;
    bus_req = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int i = 0; i < `ECC_DEPTH; i++) begin
      written[i]     = 1'b0;
      model_flips[i] = 0;
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // clean traffic on a narrow window so reads hit written words
    for (int i = 0; i < N_CLEAN; i++) begin
      r = $random(seed);
      a = {2'b00, r[5:0]};
      d = $random(seed);
      if (written[a] && r[8]) begin
        read_tracked(a, "clean read");
      end else begin
        store_word(a, d, '0, 0);
      end
    end
    idle_cycles(1);
    apb_read(REG_CNT_SINGLE, rd);
    compare_value("clean single count", 0, rd);
    apb_read(REG_CNT_DOUBLE, rd);
    compare_value("clean double count", 0, rd);

    // single-bit faults, one random bit of the 39 per word
    for (int i = 0; i < N_FAULT; i++) begin
      r  = $random(seed);
      a  = r[7:0];
      d  = $random(seed);
      b1 = {$random(seed)} % 39;
      mask = 39'd1 << b1;
      set_mask(mask);
      store_word(a, d, mask, 1);
      fault_addrs.push_back(a);
    end
    set_mask('0);
    for (int i = 0; i < N_FAULT; i++) begin
      read_tracked(fault_addrs[i], "single fault read");
      // counter lands on the edge after the response
      idle_cycles(1);
      apb_read(REG_CNT_SINGLE, rd);
      compare_value("single count", exp_single, rd);
    end
    apb_read(REG_LAST_SYND, rd);
    require(rd != 0, "last syndrome is zero after single-bit faults");

    // double-bit faults, second bit always distinct from the first
    for (int i = 0; i < N_FAULT; i++) begin
      r  = $random(seed);
      a  = r[7:0];
      d  = $random(seed);
      b1 = {$random(seed)} % 39;
      b2 = (b1 + 1 + ({$random(seed)} % 38)) % 39;
      mask = (39'd1 << b1) | (39'd1 << b2);
      set_mask(mask);
      store_word(a, d, mask, 2);
      fault_addrs.push_back(a);
    end
    set_mask('0);
    for (int i = 0; i < N_FAULT; i++) begin
      read_tracked(fault_addrs[N_FAULT + i], "double fault read");
      idle_cycles(1);
      apb_read(REG_CNT_DOUBLE, rd);
      compare_value("double count", exp_double, rd);
    end
    apb_read(REG_CNT_SINGLE, rd);
    compare_value("single count after doubles", exp_single, rd);

    // rewrite faulty words from both fault phases with a clean mask
    for (int i = 0; i < N_FAULT; i++) begin
      a = fault_addrs[2 * i];
      d = $random(seed);
      store_word(a, d, '0, 0);
      read_tracked(a, "rewrite read");
    end
    idle_cycles(1);
    apb_read(REG_CNT_SINGLE, rd);
    compare_value("single count after rewrite", exp_single, rd);
    apb_read(REG_CNT_DOUBLE, rd);
    compare_value("double count after rewrite", exp_double, rd);

    // register file readback and an unmapped address
    r = $random(seed);
    apb_write(REG_INJ_DATA, r);
    apb_read(REG_INJ_DATA, rd);
    compare_value("inject data readback", r, rd);
    r = $random(seed);
    apb_write(REG_INJ_CHECK, r);
    apb_read(REG_INJ_CHECK, rd);
    compare_value("inject check readback", {25'b0, r[6:0]}, rd);
    r = $random(seed);
    a = 8'(32'h14 + ({r} % 32'd236));
    apb_read(a, rd);
    compare_value("unmapped read", 0, rd);
    set_mask('0);

    idle_cycles(2);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+verilog
verilog/hci_bus_pkg.sv
verilog/ecc_pkg.sv
verilog/secded_39_32_enc.sv
verilog/secded_39_32_dec.sv
verilog/hci_ecc_adapter.sv
verilog/ecc_sram_bank.sv
verilog/ecc_apb_regs.sv
verilog/ecc_mem_top.sv
testbench/tb_ecc_mem.sv
